//--- rtl/ctu_seq_pkg.sv
// --------------------------------------------------------------------
// state encoding and cycle counts of the pll reset/lock sequencer
// all counts are scaled down for simulation and bear no relation
// to real pll lock times
// --------------------------------------------------------------------
package ctu_seq_pkg;

  // one-hot sequencer state as reported in STAT[4:0]
  typedef enum logic [4:0] {
    WAIT_POR = 5'b00001,
    RST_PLL  = 5'b00010,
    WAIT_LCK = 5'b00100,
    PLL_LCK  = 5'b01000,
    FREQ_CHG = 5'b10000
  } ctu_state_t;

  // counter widths
  localparam int LCK_CNT_W = 8;
  localparam int RST_CNT_W = 5;
  localparam int FC_CNT_W  = 2;
  localparam int POR_CNT_W = 3;

  // pll reset hold time
  localparam logic [RST_CNT_W-1:0] RST_PLL_CNT = 5'd16;

  // lock waits per entry path into WAIT_LCK
  localparam logic [LCK_CNT_W-1:0] PLL_LCK_CNT = 8'd200;
  localparam logic [LCK_CNT_W-1:0] BYP_LCK_CNT = 8'd8;
  localparam logic [LCK_CNT_W-1:0] WRM_LCK_CNT = 8'd60;
  localparam logic [LCK_CNT_W-1:0] TST_LCK_CNT = 8'd24;

  // frequency change command to pll reset
  localparam logic [FC_CNT_W-1:0] FC_DLY_CNT = 2'd3;

  // minimum high time of the synchronized power-on pin
  localparam logic [POR_CNT_W-1:0] POR_FILT_CNT = 3'd4;

endpackage

//--- rtl/ctu_csr_pkg.sv
// --------------------------------------------------------------------
// register map of the clock control slave
// word addresses only, byte lanes are not decoded
// --------------------------------------------------------------------
package ctu_csr_pkg;

  // register addresses
  localparam logic [3:0] CTRL_ADR = 4'h0;
  localparam logic [3:0] STAT_ADR = 4'h4;
  localparam logic [3:0] DIV_ADR  = 4'h8;

  // command bits of a CTRL write
  localparam int CMD_WRM_BIT = 0;
  localparam int CMD_TST_BIT = 1;
  localparam int CMD_FC_BIT  = 2;

  // new divider field of a CTRL write
  localparam int DIV_LSB = 8;
  localparam int DIV_W   = 6;

  // divider value out of reset
  localparam logic [DIV_W-1:0] DIV_RST = 6'd1;

  // STAT layout
  localparam int STAT_ST_MSB  = 4;
  localparam int STAT_LCK_BIT = 5;
  localparam int STAT_ERR_BIT = 6;

endpackage

//--- rtl/ctu_por_filter.sv
// --------------------------------------------------------------------
// power-on and bypass select pin conditioning
// both pins are asynchronous and get two flops each
// one por_pulse per clean low-to-high power-on sequence
// --------------------------------------------------------------------
`timescale 1ns/1ps

module ctu_por_filter (
  input  logic pll_raw_clk_out,
  input  logic rst,
  input  logic pwron_rst_l,
  input  logic bypclksel,
  output logic por_pulse,
  output logic byp_sel
);

  logic                              pwr_s1;
  logic                              pwr_s2;
  logic                              byp_s1;
  logic [ctu_seq_pkg::POR_CNT_W-1:0] hi_cnt;
  // set once the pin has been seen low
  logic                              armed;

  // synchronizers
  always_ff @(posedge pll_raw_clk_out)
  begin
    if (rst)
    begin
      pwr_s1  <= 1'b0;
      pwr_s2  <= 1'b0;
      byp_s1  <= 1'b0;
      byp_sel <= 1'b0;
    end
    else
    begin
      pwr_s1  <= pwron_rst_l;
      pwr_s2  <= pwr_s1;
      byp_s1  <= bypclksel;
      byp_sel <= byp_s1;
    end
  end

  // glitch filter, any low restarts the high-time count
  always_ff @(posedge pll_raw_clk_out)
  begin
    if (rst)
    begin
      hi_cnt    <= '0;
      armed     <= 1'b0;
      por_pulse <= 1'b0;
    end
    else
    begin
      por_pulse <= 1'b0;
      if (!pwr_s2)
      begin
        hi_cnt <= '0;
        armed  <= 1'b1;
      end
      else if (armed)
      begin
        if (hi_cnt == ctu_seq_pkg::POR_FILT_CNT - 1'b1)
        begin
          por_pulse <= 1'b1;
          armed     <= 1'b0;
        end
        else
          hi_cnt <= hi_cnt + 1'b1;
      end
    end
  end

endmodule

//--- rtl/ctu_pll_seq.sv
// --------------------------------------------------------------------
// pll reset and lock sequencer on the reference clock
// commands are one-cycle pulses and only valid in PLL_LCK
// locked comes from the state alone as no lock detector exists
// --------------------------------------------------------------------
`timescale 1ns/1ps

module ctu_pll_seq (
  input  logic                    pll_raw_clk_out,
  input  logic                    rst,
  input  logic                    por_pulse,
  input  logic                    byp_sel,
  input  logic                    cmd_wrm,
  input  logic                    cmd_tst,
  input  logic                    cmd_fc,
  input  logic                    testmode_l,
  output ctu_seq_pkg::ctu_state_t state,
  output logic                    locked,
  output logic                    div_load,
  output logic                    pll_reset_l,
  output logic                    pll_reset_dly_l
);

  ctu_seq_pkg::ctu_state_t           state_nxt;
  logic [ctu_seq_pkg::RST_CNT_W-1:0] rst_cnt;
  logic                              rst_done;
  logic [ctu_seq_pkg::LCK_CNT_W-1:0] lck_cnt;
  logic [ctu_seq_pkg::LCK_CNT_W-1:0] lck_init;
  logic                              lck_load;
  logic                              lck_done;
  logic [ctu_seq_pkg::FC_CNT_W-1:0]  fc_cnt;
  logic                              fc_done;
  // pll reset was started by a frequency change
  logic                              fc_seq;
  logic                              rst_dly1_l;
  logic                              rst_dly2_l;

  // --------------------------------------------------------------------
  // counters
  // --------------------------------------------------------------------

  // pll reset hold, up-counter cleared outside RST_PLL
  always_ff @(posedge pll_raw_clk_out)
  begin
    if (rst || state != ctu_seq_pkg::RST_PLL)
      rst_cnt <= '0;
    else
      rst_cnt <= rst_cnt + 1'b1;
  end

  assign rst_done = (rst_cnt == ctu_seq_pkg::RST_PLL_CNT - 1'b1);

  // lock wait count picked on entry to WAIT_LCK
  always_comb
  begin
    lck_init = ctu_seq_pkg::PLL_LCK_CNT;
    if (state == ctu_seq_pkg::PLL_LCK)
      lck_init = cmd_wrm ? ctu_seq_pkg::WRM_LCK_CNT : ctu_seq_pkg::TST_LCK_CNT;
    else if (!fc_seq && byp_sel)
      lck_init = ctu_seq_pkg::BYP_LCK_CNT;
  end

  assign lck_load = (state_nxt == ctu_seq_pkg::WAIT_LCK) && (state != ctu_seq_pkg::WAIT_LCK);

  // lock wait down-counter, last cycle at one
  always_ff @(posedge pll_raw_clk_out)
  begin
    if (rst)
      lck_cnt <= '0;
    else if (lck_load)
      lck_cnt <= lck_init;
    else if (state == ctu_seq_pkg::WAIT_LCK)
      lck_cnt <= lck_cnt - 1'b1;
  end

  assign lck_done = ~(|lck_cnt[ctu_seq_pkg::LCK_CNT_W-1:1]) & lck_cnt[0];

  // frequency change delay
  always_ff @(posedge pll_raw_clk_out)
  begin
    if (rst || state != ctu_seq_pkg::FREQ_CHG)
      fc_cnt <= '0;
    else
      fc_cnt <= fc_cnt + 1'b1;
  end

  assign fc_done = (fc_cnt == ctu_seq_pkg::FC_DLY_CNT - 1'b1);

  always_ff @(posedge pll_raw_clk_out)
  begin
    if (rst)
      fc_seq <= 1'b0;
    else if (state_nxt == ctu_seq_pkg::FREQ_CHG)
      fc_seq <= 1'b1;
    else if (lck_load)
      fc_seq <= 1'b0;
  end

  // --------------------------------------------------------------------
  // state machine
  // --------------------------------------------------------------------

  always_comb
  begin
    state_nxt = state;
    unique case (state)
      ctu_seq_pkg::WAIT_POR:
        if (por_pulse)
          state_nxt = ctu_seq_pkg::RST_PLL;
      ctu_seq_pkg::RST_PLL:
        if (rst_done)
          state_nxt = ctu_seq_pkg::WAIT_LCK;
      ctu_seq_pkg::WAIT_LCK:
        if (lck_done)
          state_nxt = ctu_seq_pkg::PLL_LCK;
      ctu_seq_pkg::PLL_LCK:
        // fc wins over warm and test
        if (cmd_fc)
          state_nxt = ctu_seq_pkg::FREQ_CHG;
        else if (cmd_wrm || cmd_tst)
          state_nxt = ctu_seq_pkg::WAIT_LCK;
      ctu_seq_pkg::FREQ_CHG:
        if (fc_done)
          state_nxt = ctu_seq_pkg::RST_PLL;
      default:
        state_nxt = ctu_seq_pkg::WAIT_POR;
    endcase
  end

  // outputs registered from the next state so they line up with state
  always_ff @(posedge pll_raw_clk_out)
  begin
    if (rst)
    begin
      state       <= ctu_seq_pkg::WAIT_POR;
      locked      <= 1'b0;
      div_load    <= 1'b0;
      pll_reset_l <= 1'b1;
      rst_dly1_l  <= 1'b1;
      rst_dly2_l  <= 1'b1;
    end
    else
    begin
      state       <= state_nxt;
      locked      <= (state_nxt == ctu_seq_pkg::PLL_LCK);
      div_load    <= (state == ctu_seq_pkg::PLL_LCK) && (state_nxt == ctu_seq_pkg::FREQ_CHG);
      pll_reset_l <= (state_nxt != ctu_seq_pkg::RST_PLL);
      rst_dly1_l  <= pll_reset_l;
      rst_dly2_l  <= rst_dly1_l;
    end
  end

  // falls with pll_reset_l, released two cycles later
  assign pll_reset_dly_l = !testmode_l || (pll_reset_l && rst_dly2_l);

  // --------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------

  a_state_onehot: assert property (@(posedge pll_raw_clk_out) disable iff (rst)
    $onehot(state))
    else $error("sequencer state not one-hot");

  // the register slave must gate commands with locked
  a_cmd_in_lck: assert property (@(posedge pll_raw_clk_out) disable iff (rst)
    (cmd_wrm || cmd_tst || cmd_fc) |-> (state == ctu_seq_pkg::PLL_LCK))
    else $error("command outside PLL_LCK");

endmodule

//--- rtl/ctu_csr_wb.sv
// --------------------------------------------------------------------
// wishbone classic slave for clock control commands and status
// full 32-bit word access only, one wait cycle per transfer
// commands are dropped and flagged while the pll is not locked
// --------------------------------------------------------------------
`timescale 1ns/1ps

module ctu_csr_wb (
  input  logic                          pll_raw_clk_out,
  input  logic                          rst,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [3:0]                    wb_adr,
  input  logic [31:0]                   wb_dat_w,
  output logic [31:0]                   wb_dat_r,
  output logic                          wb_ack,
  input  ctu_seq_pkg::ctu_state_t       state,
  input  logic                          locked,
  input  logic                          div_load,
  output logic                          cmd_wrm,
  output logic                          cmd_tst,
  output logic                          cmd_fc,
  output logic [ctu_csr_pkg::DIV_W-1:0] pll_div
);

  logic                          wr_ctrl;
  logic                          wr_stat;
  logic                          cmd_req;
  logic                          cmd_ok;
  logic                          err;
  logic [ctu_csr_pkg::DIV_W-1:0] div_pend;

  // single ack, dropped for a cycle between transfers
  always_ff @(posedge pll_raw_clk_out)
  begin
    if (rst)
      wb_ack <= 1'b0;
    else
      wb_ack <= wb_cyc && wb_stb && !wb_ack;
  end

  assign wr_ctrl = wb_ack && wb_we && (wb_adr == ctu_csr_pkg::CTRL_ADR);
  assign wr_stat = wb_ack && wb_we && (wb_adr == ctu_csr_pkg::STAT_ADR);

  // command decode, fc then warm then test
  assign cmd_req = wb_dat_w[ctu_csr_pkg::CMD_FC_BIT] | wb_dat_w[ctu_csr_pkg::CMD_WRM_BIT] |
                   wb_dat_w[ctu_csr_pkg::CMD_TST_BIT];
  assign cmd_ok  = wr_ctrl && locked;
  assign cmd_fc  = cmd_ok && wb_dat_w[ctu_csr_pkg::CMD_FC_BIT];
  assign cmd_wrm = cmd_ok && wb_dat_w[ctu_csr_pkg::CMD_WRM_BIT] &&
                   !wb_dat_w[ctu_csr_pkg::CMD_FC_BIT];
  assign cmd_tst = cmd_ok && wb_dat_w[ctu_csr_pkg::CMD_TST_BIT] &&
                   !wb_dat_w[ctu_csr_pkg::CMD_WRM_BIT] && !wb_dat_w[ctu_csr_pkg::CMD_FC_BIT];

  // sticky error, write one to clear
  always_ff @(posedge pll_raw_clk_out)
  begin
    if (rst)
      err <= 1'b0;
    else if (wr_ctrl && cmd_req && !locked)
      err <= 1'b1;
    else if (wr_stat && wb_dat_w[ctu_csr_pkg::STAT_ERR_BIT])
      err <= 1'b0;
  end

  // pending divider, applied when the sequencer enters FREQ_CHG
  always_ff @(posedge pll_raw_clk_out)
  begin
    if (wr_ctrl)
      div_pend <= wb_dat_w[ctu_csr_pkg::DIV_LSB +: ctu_csr_pkg::DIV_W];
  end

  always_ff @(posedge pll_raw_clk_out)
  begin
    if (rst)
      pll_div <= ctu_csr_pkg::DIV_RST;
    else if (div_load)
      pll_div <= div_pend;
  end

  // read mux
  always_comb
  begin
    wb_dat_r = '0;
    case (wb_adr)
      ctu_csr_pkg::CTRL_ADR:
        wb_dat_r[ctu_csr_pkg::DIV_LSB +: ctu_csr_pkg::DIV_W] = div_pend;
      ctu_csr_pkg::STAT_ADR:
      begin
        wb_dat_r[ctu_csr_pkg::STAT_ST_MSB:0]  = state;
        wb_dat_r[ctu_csr_pkg::STAT_LCK_BIT]   = locked;
        wb_dat_r[ctu_csr_pkg::STAT_ERR_BIT]   = err;
      end
      ctu_csr_pkg::DIV_ADR:
        wb_dat_r[ctu_csr_pkg::DIV_W-1:0] = pll_div;
      default:
        wb_dat_r = '0;
    endcase
  end

  // master must hold the request through the ack cycle
  a_ack_in_cycle: assert property (@(posedge pll_raw_clk_out) disable iff (rst)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("wb_ack without cyc and stb");

endmodule

//--- rtl/ctu_clsp_top.sv
// --------------------------------------------------------------------
// clock control slice on the pll reference clock
// no pll model inside, pll_locked is the sequencer view only
// --------------------------------------------------------------------
`timescale 1ns/1ps

module ctu_clsp_top (
  input  logic                          pll_raw_clk_out,
  input  logic                          rst,
  // wishbone slave
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [3:0]                    wb_adr,
  input  logic [31:0]                   wb_dat_w,
  output logic [31:0]                   wb_dat_r,
  output logic                          wb_ack,
  // pins
  input  logic                          pwron_rst_l,
  input  logic                          bypclksel,
  input  logic                          testmode_l,
  // pll control
  output logic                          pll_reset_l,
  output logic                          pll_reset_dly_l,
  output logic                          pll_locked,
  output logic [ctu_csr_pkg::DIV_W-1:0] pll_div
);

  logic                    por_pulse;
  logic                    byp_sel;
  logic                    cmd_wrm;
  logic                    cmd_tst;
  logic                    cmd_fc;
  logic                    div_load;
  ctu_seq_pkg::ctu_state_t state;

  ctu_por_filter ctu_por_filter_i (
    .pll_raw_clk_out (pll_raw_clk_out),
    .rst             (rst),
    .pwron_rst_l     (pwron_rst_l),
    .bypclksel       (bypclksel),
    .por_pulse       (por_pulse),
    .byp_sel         (byp_sel)
  );

  ctu_pll_seq ctu_pll_seq_i (
    .pll_raw_clk_out (pll_raw_clk_out),
    .rst             (rst),
    .por_pulse       (por_pulse),
    .byp_sel         (byp_sel),
    .cmd_wrm         (cmd_wrm),
    .cmd_tst         (cmd_tst),
    .cmd_fc          (cmd_fc),
    .testmode_l      (testmode_l),
    .state           (state),
    .locked          (pll_locked),
    .div_load        (div_load),
    .pll_reset_l     (pll_reset_l),
    .pll_reset_dly_l (pll_reset_dly_l)
  );

  ctu_csr_wb ctu_csr_wb_i (
    .pll_raw_clk_out (pll_raw_clk_out),
    .rst             (rst),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack),
    .state           (state),
    .locked          (pll_locked),
    .div_load        (div_load),
    .cmd_wrm         (cmd_wrm),
    .cmd_tst         (cmd_tst),
    .cmd_fc          (cmd_fc),
    .pll_div         (pll_div)
  );

endmodule

//--- tb/tb_ctu_clsp.sv
// --------------------------------------------------------------------
// testbench for the clock control slice, single wishbone master
// outputs are sampled on the falling clock edge
// expects the scaled sequencer counts of the design package
// --------------------------------------------------------------------
`timescale 1ns/1ps

module tb_ctu_clsp;

  localparam int EV_POR      = 0;
  localparam int EV_CMD      = 1;
  localparam int EV_DROP     = 2;
  // about twice the sum of the scripted waits
  localparam int CYCLE_LIMIT = 4000;

  logic                          clk;
  logic                          rst;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [3:0]                    wb_adr;
  logic [31:0]                   wb_dat_w;
  logic [31:0]                   wb_dat_r;
  logic                          wb_ack;
  logic                          pwron_rst_l;
  logic                          bypclksel;
  logic                          testmode_l;
  logic                          pll_reset_l;
  logic                          pll_reset_dly_l;
  logic                          pll_locked;
  logic [ctu_csr_pkg::DIV_W-1:0] pll_div;

  int          cycles;
  int          errors;
  int          checks;
  int          tests;
  int          test_err0;
  string       waiting_for;
  logic [31:0] seed;

  // monitor results
  int   rst_fall_cyc;
  int   rst_rise_cyc;
  int   dly_rise_cyc;
  int   lck_fall_cyc;
  int   lck_rise_cyc;
  int   rst_pulses;
  int   dly_falls;
  int   lock_rises;
  logic prev_rst_l;
  logic prev_dly_l;
  logic prev_lck;
  event lock_ev;

  // what the next pll_locked rise belongs to
  int          cur_ev;
  logic [2:0]  cur_cmd;
  logic        cur_byp;
  int          pulses_at_cmd;
  int          lock_mark;

  int                            cmp_n;
  int                            i;
  int                            n_before;
  ctu_seq_pkg::ctu_state_t       exp_st;
  ctu_seq_pkg::ctu_state_t       cmp_st;
  logic [31:0]                   rd;
  logic [2:0]                    cmd;
  logic [ctu_csr_pkg::DIV_W-1:0] div;

  ctu_clsp_top ctu_clsp_top_i (
    .pll_raw_clk_out (clk),
    .rst             (rst),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack),
    .pwron_rst_l     (pwron_rst_l),
    .bypclksel       (bypclksel),
    .testmode_l      (testmode_l),
    .pll_reset_l     (pll_reset_l),
    .pll_reset_dly_l (pll_reset_dly_l),
    .pll_locked      (pll_locked),
    .pll_div         (pll_div)
  );

  always #20 clk = ~clk;

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------

  function automatic int rnd(input int range);
    seed = seed * 32'd1103515245 + 32'd12345;
    return int'(seed[30:16]) % range;
  endfunction

  // expected lock wait and the state right after the event
  function automatic int ref_lock(input logic [2:0] c, input logic byp, input int ev,
                                  output ctu_seq_pkg::ctu_state_t st);
    int n;
    n  = 0;
    st = ctu_seq_pkg::PLL_LCK;
    if (ev == EV_POR)
    begin
      st = ctu_seq_pkg::RST_PLL;
      n  = byp ? int'(ctu_seq_pkg::BYP_LCK_CNT) : int'(ctu_seq_pkg::PLL_LCK_CNT);
    end
    else if (ev == EV_DROP)
      st = ctu_seq_pkg::WAIT_LCK;
    else if (c[ctu_csr_pkg::CMD_FC_BIT])
    begin
      st = ctu_seq_pkg::FREQ_CHG;
      n  = int'(ctu_seq_pkg::PLL_LCK_CNT);
    end
    else if (c[ctu_csr_pkg::CMD_WRM_BIT])
    begin
      st = ctu_seq_pkg::WAIT_LCK;
      n  = int'(ctu_seq_pkg::WRM_LCK_CNT);
    end
    else if (c[ctu_csr_pkg::CMD_TST_BIT])
    begin
      st = ctu_seq_pkg::WAIT_LCK;
      n  = int'(ctu_seq_pkg::TST_LCK_CNT);
    end
    return n;
  endfunction

  function automatic logic [31:0] stat_word(input ctu_seq_pkg::ctu_state_t st,
                                            input logic lck, input logic err);
    logic [31:0] w;
    w = 32'd0;
    w[ctu_csr_pkg::STAT_ST_MSB:0] = st;
    w[ctu_csr_pkg::STAT_LCK_BIT]  = lck;
    w[ctu_csr_pkg::STAT_ERR_BIT]  = err;
    return w;
  endfunction

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_state(input string name, input ctu_seq_pkg::ctu_state_t got,
                             input ctu_seq_pkg::ctu_state_t exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // ack is due on the cycle after the request is seen
  task automatic wait_ack();
    int waits;
    waits = 0;
    @(negedge clk);
    while (!wb_ack)
    begin
      waits++;
      @(negedge clk);
    end
    check_count("wb_ack wait cycles", waits, 1);
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
    @(posedge clk);
    wb_cyc      <= 1'b1;
    wb_stb      <= 1'b1;
    wb_we       <= 1'b1;
    wb_adr      <= adr;
    wb_dat_w    <= dat;
    waiting_for = "wb_ack of a write";
    wait_ack();
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
    @(posedge clk);
    wb_cyc      <= 1'b1;
    wb_stb      <= 1'b1;
    wb_we       <= 1'b0;
    wb_adr      <= adr;
    waiting_for = "wb_ack of a read";
    wait_ack();
    dat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic issue_cmd(input logic [2:0] c, input logic [ctu_csr_pkg::DIV_W-1:0] d);
    cur_ev        = EV_CMD;
    cur_cmd       = c;
    pulses_at_cmd = rst_pulses;
    lock_mark     = lock_rises;
    wb_write(ctu_csr_pkg::CTRL_ADR, {18'd0, d, 5'd0, c});
  endtask

  task automatic wait_lock(input string what);
    waiting_for = what;
    while (lock_rises == lock_mark)
      @(negedge clk);
    // lets the compare process finish first
    @(posedge clk);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_err0)
      $display("test %0d %s: ok", tests, name);
    else
      $display("test %0d %s: %0d errors", tests, name, errors - test_err0);
    test_err0 = errors;
  endtask

  // --------------------------------------------------------------------
  // monitor, compare and timeout
  // --------------------------------------------------------------------

  always @(negedge clk)
  begin
    if (prev_rst_l && !pll_reset_l)
    begin
      rst_fall_cyc = cycles;
      rst_pulses++;
    end
    if (!prev_rst_l && pll_reset_l)
      rst_rise_cyc = cycles;
    if (prev_dly_l && !pll_reset_dly_l)
      dly_falls++;
    if (!prev_dly_l && pll_reset_dly_l)
      dly_rise_cyc = cycles;
    if (prev_lck && !pll_locked)
      lck_fall_cyc = cycles;
    if (!prev_lck && pll_locked)
    begin
      lck_rise_cyc = cycles;
      lock_rises++;
      -> lock_ev;
    end
    prev_rst_l = pll_reset_l;
    prev_dly_l = pll_reset_dly_l;
    prev_lck   = pll_locked;
  end

  always @(lock_ev)
  begin
    cmp_n = ref_lock(cur_cmd, cur_byp, cur_ev, cmp_st);
    if (cmp_st == ctu_seq_pkg::WAIT_LCK)
    begin
      // warm or test reset, no pll reset pulse
      check_count("pll_locked low cycles", lck_rise_cyc - lck_fall_cyc, cmp_n);
      check_count("pll_reset_l pulses", rst_pulses, pulses_at_cmd);
    end
    else
    begin
      check_count("pll_reset_l low cycles", rst_rise_cyc - rst_fall_cyc,
                  int'(ctu_seq_pkg::RST_PLL_CNT));
      check_count("pll_locked after pll_reset_l", lck_rise_cyc - rst_rise_cyc, cmp_n);
      check_count("pll_reset_l pulses", rst_pulses, pulses_at_cmd + 1);
      if (testmode_l)
        check_count("pll_reset_dly_l lag", dly_rise_cyc - rst_rise_cyc, 2);
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles, %s never came", cycles, waiting_for);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------

  initial
  begin
    clk         = 1'b0;
    rst         = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = 4'h0;
    wb_dat_w    = 32'd0;
    pwron_rst_l = 1'b0;
    bypclksel   = 1'b0;
    testmode_l  = 1'b1;
    cycles      = 0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_err0   = 0;
    seed        = 32'd65;
    rst_pulses  = 0;
    dly_falls   = 0;
    lock_rises  = 0;
    prev_rst_l  = 1'b1;
    prev_dly_l  = 1'b1;
    prev_lck    = 1'b0;
    cur_cmd     = 3'b000;
    cur_byp     = 1'b0;
    waiting_for = "end of reset";
    repeat (16)
      @(posedge clk);
    rst <= 1'b0;

    // 1: power-on, bypass off
    repeat (4)
      @(posedge clk);
    cur_ev        = EV_POR;
    pulses_at_cmd = rst_pulses;
    lock_mark     = lock_rises;
    pwron_rst_l   <= 1'b1;
    wait_lock("pll_locked rise after power-on");
    void'(ref_lock(3'b000, 1'b0, EV_CMD, exp_st));
    wb_read(ctu_csr_pkg::STAT_ADR, rd);
    check_word("wb_dat_r STAT", rd, stat_word(exp_st, 1'b1, 1'b0));
    end_test("power-on");

    // 2: reset, glitch, then power-on with bypass
    @(posedge clk);
    rst         <= 1'b1;
    pwron_rst_l <= 1'b0;
    bypclksel   <= 1'b1;
    repeat (16)
      @(posedge clk);
    rst <= 1'b0;
    repeat (4)
      @(posedge clk);
    n_before    = rst_pulses;
    pwron_rst_l <= 1'b1;
    repeat (2)
      @(posedge clk);
    pwron_rst_l <= 1'b0;
    repeat (12)
      @(posedge clk);
    check_count("pll_reset_l pulses after glitch", rst_pulses, n_before);
    cur_ev        = EV_POR;
    cur_byp       = 1'b1;
    pulses_at_cmd = rst_pulses;
    lock_mark     = lock_rises;
    pwron_rst_l   <= 1'b1;
    wait_lock("pll_locked rise after bypass power-on");
    end_test("bypass power-on");

    // 3: warm and test resets, first write has both bits
    for (i = 0; i < 6; i++)
    begin
      repeat (rnd(8) + 1)
        @(posedge clk);
      if (i == 0)
        cmd = 3'b011;
      else if (rnd(2) == 0)
        cmd = 3'b001;
      else
        cmd = 3'b010;
      void'(ref_lock(cmd, cur_byp, EV_CMD, exp_st));
      issue_cmd(cmd, 6'd0);
      wb_read(ctu_csr_pkg::STAT_ADR, rd);
      check_state("wb_dat_r STAT state", ctu_seq_pkg::ctu_state_t'(rd[4:0]), exp_st);
      wait_lock("pll_locked rise after warm or test reset");
    end
    end_test("warm and test resets");

    // 4: frequency change, extra bits lose to fc
    div = ctu_csr_pkg::DIV_W'(rnd(64));
    cmd = 3'b100 | 3'(rnd(3) + 1);
    void'(ref_lock(cmd, cur_byp, EV_CMD, exp_st));
    issue_cmd(cmd, div);
    wb_read(ctu_csr_pkg::STAT_ADR, rd);
    check_state("wb_dat_r STAT state", ctu_seq_pkg::ctu_state_t'(rd[4:0]), exp_st);
    wait_lock("pll_locked rise after frequency change");
    wb_read(ctu_csr_pkg::DIV_ADR, rd);
    check_word("wb_dat_r DIV", rd, {26'd0, div});
    check_word("pll_div", {26'd0, pll_div}, {26'd0, div});
    end_test("frequency change");

    // 5: command while not locked is dropped
    issue_cmd(3'b001, 6'd0);
    repeat (4)
      @(posedge clk);
    wb_write(ctu_csr_pkg::CTRL_ADR, 32'h0000_0006);
    void'(ref_lock(3'b110, cur_byp, EV_DROP, exp_st));
    wb_read(ctu_csr_pkg::STAT_ADR, rd);
    check_state("wb_dat_r STAT state", ctu_seq_pkg::ctu_state_t'(rd[4:0]), exp_st);
    check_word("wb_dat_r STAT", rd, stat_word(exp_st, 1'b0, 1'b1));
    wait_lock("pll_locked rise after warm reset");
    wb_read(ctu_csr_pkg::STAT_ADR, rd);
    check_word("wb_dat_r STAT", rd, stat_word(ctu_seq_pkg::PLL_LCK, 1'b1, 1'b1));
    wb_write(ctu_csr_pkg::STAT_ADR, 32'h0000_0040);
    wb_read(ctu_csr_pkg::STAT_ADR, rd);
    check_word("wb_dat_r STAT", rd, stat_word(ctu_seq_pkg::PLL_LCK, 1'b1, 1'b0));
    end_test("dropped command");

    // 6: test mode holds the delayed reset off
    @(posedge clk);
    testmode_l <= 1'b0;
    n_before = dly_falls;
    div = ctu_csr_pkg::DIV_W'(rnd(64));
    issue_cmd(3'b100, div);
    wait_lock("pll_locked rise after test mode frequency change");
    check_count("pll_reset_dly_l falls", dly_falls, n_before);
    testmode_l <= 1'b1;
    end_test("test mode frequency change");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- compile.f
rtl/ctu_seq_pkg.sv
rtl/ctu_csr_pkg.sv
rtl/ctu_por_filter.sv
rtl/ctu_pll_seq.sv
rtl/ctu_csr_wb.sv
rtl/ctu_clsp_top.sv
tb/tb_ctu_clsp.sv

//--- run.sh
#!/bin/sh
# builds the clock control slice testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
  --top-module tb_ctu_clsp -o sim_ctu_clsp

out=$(./obj_dir/sim_ctu_clsp)
echo "$out"

# pass only if the testbench printed its pass line
echo "$out" | grep -q "^RESULT: PASS$"
